// ==== hw/fdiv_pkg.sv ====
package fdiv_pkg;

	// Single-precision field widths.
	localparam int EXP_WIDTH = 8;
	localparam int MANT_WIDTH = 23;
	localparam int FP_WIDTH = 1 + EXP_WIDTH + MANT_WIDTH;

	localparam int EXP_BIAS = 127;

	// Working widths of the recurrence.
	localparam int CALC_EXP_WIDTH = 10;
	localparam int QUOT_WIDTH = 26;
	localparam int REM_WIDTH = 28;
	localparam int RND_MANT_WIDTH = 25;
	localparam int GRS_WIDTH = 3;

	localparam logic signed [CALC_EXP_WIDTH-1:0] CALC_BIAS = CALC_EXP_WIDTH'(EXP_BIAS);

	// The root always loses one bit in normalization, so the halved exponent is one high.
	localparam logic signed [CALC_EXP_WIDTH-1:0] SQRT_EXP_OFFSET =
		CALC_EXP_WIDTH'(EXP_BIAS - 2);

	localparam logic [EXP_WIDTH-1:0] EXP_MAX = '1;

	// +1.0, the implicit divisor of a square root.
	localparam logic [FP_WIDTH-1:0] FP_ONE = {
		1'b0,
		1'b0,
		{(EXP_WIDTH-1){1'b1}},
		{MANT_WIDTH{1'b0}}
	};

	// Low bit is the sign.
	typedef enum logic [3:0] {
		CLASS_POS_ZERO   = 4'b0000,
		CLASS_NEG_ZERO   = 4'b0001,
		CLASS_POS_NORMAL = 4'b0010,
		CLASS_NEG_NORMAL = 4'b0011,
		CLASS_POS_INF    = 4'b0100,
		CLASS_NEG_INF    = 4'b0101,
		CLASS_POS_SNAN   = 4'b0110,
		CLASS_NEG_SNAN   = 4'b0111,
		CLASS_POS_QNAN   = 4'b1000,
		CLASS_NEG_QNAN   = 4'b1001
	} operand_class_t;

	typedef struct packed {
		logic snan; // Invalid operation.
		logic qnan;
		logic dbz;
		logic inf;
		logic zero;
	} fdiv_flags_t;

endpackage

// ==== hw/fdiv_operand_if.sv ====
`timescale 1ns/1ps

interface fdiv_operand_if
	import fdiv_pkg::*;
();

	logic load; // One cycle after an accepted start.
	logic op_sqrt;
	logic [REM_WIDTH-1:0] rem_init;
	logic [REM_WIDTH-1:0] divisor;
	logic sign;
	logic signed [CALC_EXP_WIDTH-1:0] exponent; // Unbiased.

	modport stage (
		output load,
		output op_sqrt,
		output rem_init,
		output divisor,
		output sign,
		output exponent
	);

	modport iter (
		input load,
		input op_sqrt,
		input rem_init,
		input divisor
	);

	modport norm (input sign, input exponent);

endinterface

// ==== hw/fdiv_operand_stage.sv ====
`timescale 1ns/1ps

module fdiv_operand_stage
	import fdiv_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic start_i,
	input logic op_sqrt_i,
	input logic [FP_WIDTH-1:0] a_i,
	input logic [FP_WIDTH-1:0] b_i,
	input logic busy_i,
	output fdiv_flags_t flags_o,
	fdiv_operand_if.stage op_if
);

	logic accept;
	logic [FP_WIDTH-1:0] b_eff;
	operand_class_t class_a;
	operand_class_t class_b;
	fdiv_flags_t flags_d;
	logic signed [CALC_EXP_WIDTH-1:0] exp_a;
	logic signed [CALC_EXP_WIDTH-1:0] exp_b;
	logic signed [CALC_EXP_WIDTH-1:0] exponent_d;
	logic [REM_WIDTH-1:0] rem_d;
	logic [REM_WIDTH-1:0] divisor_d;

	// Subnormals fall into the zero class.
	function automatic operand_class_t classify(input logic [FP_WIDTH-1:0] x);
		logic [EXP_WIDTH-1:0] e;
		logic [MANT_WIDTH-1:0] f;
		logic [3:0] kind;
		e = x[FP_WIDTH-2 -: EXP_WIDTH];
		f = x[MANT_WIDTH-1:0];
		if (e == '0) begin
			kind = CLASS_POS_ZERO;
		end else if (e != EXP_MAX) begin
			kind = CLASS_POS_NORMAL;
		end else if (f == '0) begin
			kind = CLASS_POS_INF;
		end else if (f[MANT_WIDTH-1]) begin
			kind = CLASS_POS_QNAN;
		end else begin
			kind = CLASS_POS_SNAN;
		end
		return operand_class_t'({kind[3:1], x[FP_WIDTH-1]});
	endfunction

	function automatic logic is_zero(input operand_class_t c);
		return (c == CLASS_POS_ZERO) || (c == CLASS_NEG_ZERO);
	endfunction

	function automatic logic is_normal(input operand_class_t c);
		return (c == CLASS_POS_NORMAL) || (c == CLASS_NEG_NORMAL);
	endfunction

	function automatic logic is_inf(input operand_class_t c);
		return (c == CLASS_POS_INF) || (c == CLASS_NEG_INF);
	endfunction

	function automatic logic is_snan(input operand_class_t c);
		return (c == CLASS_POS_SNAN) || (c == CLASS_NEG_SNAN);
	endfunction

	function automatic logic is_qnan(input operand_class_t c);
		return (c == CLASS_POS_QNAN) || (c == CLASS_NEG_QNAN);
	endfunction

	assign accept = start_i & ~busy_i;
	assign b_eff = op_sqrt_i ? FP_ONE : b_i;
	assign class_a = classify(a_i);
	assign class_b = classify(b_eff);

	always_comb begin
		flags_d = '0;
		if (is_snan(class_a) | is_snan(class_b)) begin
			flags_d.snan = 1'b1;
		end else if (is_zero(class_a) & is_zero(class_b)) begin
			flags_d.snan = 1'b1; // 0/0.
		end else if (is_inf(class_a) & is_inf(class_b)) begin
			flags_d.snan = 1'b1;
		end else if (is_qnan(class_a) | is_qnan(class_b)) begin
			flags_d.qnan = 1'b1;
		end
		if (is_inf(class_a) & (is_normal(class_b) | is_zero(class_b))) begin
			flags_d.inf = 1'b1;
		end else if (is_zero(class_b) & is_normal(class_a)) begin
			flags_d.dbz = 1'b1;
		end
		if (is_zero(class_a) | is_inf(class_b)) begin
			flags_d.zero = 1'b1;
		end
		if (op_sqrt_i) begin
			if (class_a == CLASS_POS_INF) begin
				flags_d.inf = 1'b1;
			end
			if ((class_a == CLASS_NEG_INF) || (class_a == CLASS_NEG_NORMAL)) begin
				flags_d.snan = 1'b1; // Root of a negative number.
			end
		end
	end

	always_comb begin
		exp_a = {2'b00, a_i[FP_WIDTH-2 -: EXP_WIDTH]};
		exp_b = {2'b00, b_eff[FP_WIDTH-2 -: EXP_WIDTH]};
		exponent_d = exp_a - exp_b;
		rem_d = {{(REM_WIDTH-MANT_WIDTH-1){1'b0}}, 1'b1, a_i[MANT_WIDTH-1:0]};
		divisor_d = {{(REM_WIDTH-MANT_WIDTH-2){1'b0}}, 1'b1, b_eff[MANT_WIDTH-1:0], 1'b0};
		if (op_sqrt_i) begin
			exponent_d = (exp_a - SQRT_EXP_OFFSET) >>> 1;
			divisor_d = '0;
			if (!a_i[MANT_WIDTH]) begin
				rem_d = rem_d << 1; // Even biased exponent.
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			op_if.load <= 1'b0;
			flags_o <= '0;
		end else begin
			op_if.load <= accept;
			if (accept) begin
				flags_o <= flags_d;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op_if.op_sqrt <= op_sqrt_i;
			op_if.rem_init <= rem_d;
			op_if.divisor <= divisor_d;
			op_if.sign <= a_i[FP_WIDTH-1] ^ b_eff[FP_WIDTH-1];
			op_if.exponent <= exponent_d;
		end
	end

endmodule

// ==== hw/fdiv_iterate.sv ====
`timescale 1ns/1ps

module fdiv_iterate
	import fdiv_pkg::*;
(
	input logic clock,
	input logic reset,
	fdiv_operand_if.iter op_if,
	output logic busy_o,
	output logic quot_valid_o,
	output logic [QUOT_WIDTH-1:0] quotient_o,
	output logic [REM_WIDTH-2:0] remainder_o
);

	localparam int CNT_WIDTH = $clog2(QUOT_WIDTH);

	// Index of the first quotient bit.
	localparam logic [CNT_WIDTH-1:0] DIV_START = CNT_WIDTH'(QUOT_WIDTH - 1);
	localparam logic [CNT_WIDTH-1:0] SQRT_START = CNT_WIDTH'(QUOT_WIDTH - 2);

	logic running;
	logic drain;
	logic [CNT_WIDTH-1:0] count;
	logic [REM_WIDTH-1:0] rem_q;
	logic [QUOT_WIDTH-1:0] quot_q;
	logic [REM_WIDTH-1:0] rem_shift;
	logic [REM_WIDTH-1:0] trial;
	logic [REM_WIDTH-1:0] diff;
	logic take;

	assign rem_shift = rem_q << 1;

	// Root trial value is twice the partial root with the current bit set.
	always_comb begin
		trial = op_if.divisor;
		if (op_if.op_sqrt) begin
			trial = {1'b0, quot_q, 1'b0};
			trial[count] = 1'b1;
		end
	end

	assign diff = rem_shift - trial;
	assign take = ~diff[REM_WIDTH-1]; // Difference is non-negative.

	always_ff @(posedge clock) begin
		if (!reset) begin
			running <= 1'b0;
			count <= '0;
			quot_valid_o <= 1'b0;
			drain <= 1'b0;
		end else begin
			quot_valid_o <= 1'b0;
			drain <= quot_valid_o;
			if (op_if.load) begin
				running <= 1'b1;
				count <= op_if.op_sqrt ? SQRT_START : DIV_START;
			end else if (running) begin
				if (count == '0) begin
					running <= 1'b0;
					quot_valid_o <= 1'b1;
				end else begin
					count <= count - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (op_if.load) begin
			rem_q <= op_if.rem_init;
			quot_q <= '0;
		end else if (running) begin
			rem_q <= take ? diff : rem_shift;
			quot_q[count] <= take;
		end
	end

	assign quotient_o = quot_q;
	assign remainder_o = rem_q[REM_WIDTH-2:0];

	// Covers the normalize cycle as well.
	assign busy_o = op_if.load | running | quot_valid_o | drain;

endmodule

// ==== hw/fdiv_normalize.sv ====
`timescale 1ns/1ps

module fdiv_normalize
	import fdiv_pkg::*;
(
	input logic clock,
	input logic reset,
	fdiv_operand_if.norm op_if,
	input logic quot_valid_i,
	input logic [QUOT_WIDTH-1:0] quotient_i,
	input logic [REM_WIDTH-2:0] remainder_i,
	output logic done_o,
	output logic sign_o,
	output logic [CALC_EXP_WIDTH-1:0] exponent_o,
	output logic [RND_MANT_WIDTH-1:0] mantissa_o,
	output logic [GRS_WIDTH-1:0] grs_o
);

	localparam int WIDE_WIDTH = QUOT_WIDTH + REM_WIDTH - 1 + RND_MANT_WIDTH;
	localparam int MAX_RSHIFT = RND_MANT_WIDTH;
	localparam int SHIFT_WIDTH = $clog2(MAX_RSHIFT + 1);
	localparam int STICKY_WIDTH = WIDE_WIDTH - (RND_MANT_WIDTH - 1) - 2;

	logic [WIDE_WIDTH-1:0] wide;
	logic [WIDE_WIDTH-1:0] normed;
	logic [WIDE_WIDTH-1:0] shifted;
	logic lead_shift;
	logic signed [CALC_EXP_WIDTH-1:0] exp_biased;
	logic signed [CALC_EXP_WIDTH-1:0] exp_final;
	logic signed [CALC_EXP_WIDTH-1:0] shift_full;
	logic [SHIFT_WIDTH-1:0] rshift;
	logic [RND_MANT_WIDTH-1:0] mant_d;
	logic [GRS_WIDTH-1:0] grs_d;

	always_comb begin
		// Low zeros give room for the subnormal shift.
		wide = {quotient_i, remainder_i, {RND_MANT_WIDTH{1'b0}}};
		lead_shift = ~wide[WIDE_WIDTH-1];
		normed = wide << lead_shift;
		exp_biased = op_if.exponent + CALC_BIAS
			- $signed({{(CALC_EXP_WIDTH-1){1'b0}}, lead_shift});
		shift_full = CALC_EXP_WIDTH'(1) - exp_biased;

		rshift = '0;
		exp_final = exp_biased;
		if (exp_biased <= 0) begin
			rshift = SHIFT_WIDTH'(MAX_RSHIFT); // Everything lands in sticky.
			if (exp_biased > -MAX_RSHIFT) begin
				rshift = shift_full[SHIFT_WIDTH-1:0];
			end
			exp_final = '0;
		end
		shifted = normed >> rshift;

		mant_d = {1'b0, shifted[WIDE_WIDTH-1 -: RND_MANT_WIDTH-1]};
		grs_d = {shifted[STICKY_WIDTH+1 -: 2], |shifted[STICKY_WIDTH-1:0]};
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			done_o <= 1'b0;
		end else begin
			done_o <= quot_valid_i;
		end
	end

	// Result holds until the next quotient.
	always_ff @(posedge clock) begin
		if (quot_valid_i) begin
			sign_o <= op_if.sign;
			exponent_o <= exp_final;
			mantissa_o <= mant_d;
			grs_o <= grs_d;
		end
	end

endmodule

// ==== hw/fp_fdiv_top.sv ====
`timescale 1ns/1ps

module fp_fdiv_top
	import fdiv_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic start_i,
	input logic op_sqrt_i,
	input logic [FP_WIDTH-1:0] a_i,
	input logic [FP_WIDTH-1:0] b_i,
	output logic busy_o,
	output logic done_o,
	output logic sign_o,
	output logic [CALC_EXP_WIDTH-1:0] exponent_o,
	output logic [RND_MANT_WIDTH-1:0] mantissa_o,
	output logic [GRS_WIDTH-1:0] grs_o,
	output logic snan_o,
	output logic qnan_o,
	output logic dbz_o,
	output logic inf_o,
	output logic zero_o
);

	logic busy;
	fdiv_flags_t flags;
	logic quot_valid;
	logic [QUOT_WIDTH-1:0] quotient;
	logic [REM_WIDTH-2:0] remainder;

	fdiv_operand_if u_op_if ();

	fdiv_operand_stage u_operand_stage (
		.clock     (clock),
		.reset     (reset),
		.start_i   (start_i),
		.op_sqrt_i (op_sqrt_i),
		.a_i       (a_i),
		.b_i       (b_i),
		.busy_i    (busy),
		.flags_o   (flags),
		.op_if     (u_op_if.stage)
	);

	fdiv_iterate u_iterate (
		.clock        (clock),
		.reset        (reset),
		.op_if        (u_op_if.iter),
		.busy_o       (busy),
		.quot_valid_o (quot_valid),
		.quotient_o   (quotient),
		.remainder_o  (remainder)
	);

	fdiv_normalize u_normalize (
		.clock        (clock),
		.reset        (reset),
		.op_if        (u_op_if.norm),
		.quot_valid_i (quot_valid),
		.quotient_i   (quotient),
		.remainder_i  (remainder),
		.done_o       (done_o),
		.sign_o       (sign_o),
		.exponent_o   (exponent_o),
		.mantissa_o   (mantissa_o),
		.grs_o        (grs_o)
	);

	assign busy_o = busy;
	assign snan_o = flags.snan;
	assign qnan_o = flags.qnan;
	assign dbz_o = flags.dbz;
	assign inf_o = flags.inf;
	assign zero_o = flags.zero;

endmodule

// ==== verification/fp_fdiv_assertions.sv ====
`timescale 1ns/1ps

module fp_fdiv_assertions
	import fdiv_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic start_i,
	input logic op_sqrt_i,
	input logic [FP_WIDTH-1:0] a_i,
	input logic [FP_WIDTH-1:0] b_i,
	input logic busy_o,
	input logic done_o,
	input logic sign_o,
	input logic [CALC_EXP_WIDTH-1:0] exponent_o,
	input logic [RND_MANT_WIDTH-1:0] mantissa_o,
	input logic [GRS_WIDTH-1:0] grs_o,
	input logic snan_o,
	input logic qnan_o,
	input logic dbz_o,
	input logic inf_o,
	input logic zero_o
);

	int error_count = 0;
	logic accept;
	fdiv_flags_t want_flags;
	logic want_sign;
	logic [CALC_EXP_WIDTH-1:0] want_exponent;
	logic [RND_MANT_WIDTH-1:0] want_mantissa;
	logic [GRS_WIDTH-1:0] want_grs;
	logic check_data;

	function automatic logic is_normal(input logic [FP_WIDTH-1:0] x);
		return (x[30:23] != 8'h00) && (x[30:23] != 8'hff);
	endfunction

	// Largest r with r * r <= x.
	function automatic longint unsigned int_sqrt(input longint unsigned x);
		longint unsigned lo;
		longint unsigned hi;
		longint unsigned mid;
		lo = 0;
		hi = 64'd1 << 26;
		while (hi - lo > 1) begin
			mid = (lo + hi) >> 1;
			if (mid * mid <= x) begin
				lo = mid;
			end else begin
				hi = mid;
			end
		end
		return lo;
	endfunction

	function automatic fdiv_flags_t special_flags(input logic [FP_WIDTH-1:0] a,
			input logic [FP_WIDTH-1:0] b_raw, input logic sqrt);
		logic [FP_WIDTH-1:0] b;
		logic za;
		logic zb;
		logic ia;
		logic ib;
		logic na;
		logic nb;
		logic invalid;
		fdiv_flags_t f;
		b = sqrt ? 32'h3f80_0000 : b_raw;
		za = a[30:23] == 8'h00; // Subnormals count as zero.
		zb = b[30:23] == 8'h00;
		ia = a[30:0] == 31'h7f80_0000;
		ib = b[30:0] == 31'h7f80_0000;
		na = (a[30:23] == 8'hff) && !ia;
		nb = (b[30:23] == 8'hff) && !ib;
		invalid = (na && !a[22]) || (nb && !b[22]) || (za && zb) || (ia && ib);
		f.snan = invalid || (sqrt && a[31] && !za && !na);
		f.qnan = !invalid && (na || nb);
		f.inf = ia && !nb && !ib;
		f.dbz = zb && !za && !ia && !na;
		f.zero = za || ib;
		return f;
	endfunction

	// Exponent, mantissa and guard bits as one vector.
	function automatic logic [37:0] reference_value(input logic [FP_WIDTH-1:0] a,
			input logic [FP_WIDTH-1:0] b, input logic sqrt);
		logic [23:0] ma;
		logic [23:0] mb;
		logic [49:0] num;
		longint unsigned root;
		logic [77:0] wide;
		int e;
		int sh;
		ma = {1'b1, a[22:0]};
		mb = {1'b1, b[22:0]};
		if (sqrt) begin
			num = 50'(ma) << (a[23] ? 25 : 26); // Odd biased exponent needs no extra shift.
			root = int_sqrt(64'(num));
			wide = {25'(root), 27'(64'(num) - root * root), 26'b0};
			e = ((int'(a[30:23]) - EXP_BIAS) >>> 1) + EXP_BIAS;
		end else begin
			num = 50'(ma) << 26;
			wide = {26'(num / (50'(mb) << 1)), 27'(num % (50'(mb) << 1)), 25'b0};
			e = int'(a[30:23]) - int'(b[30:23]) + EXP_BIAS;
		end
		if (!wide[77]) begin
			wide = wide << 1;
			e = e - 1;
		end
		if (e <= 0) begin
			sh = (1 - e > RND_MANT_WIDTH) ? RND_MANT_WIDTH : 1 - e;
			wide = wide >> sh;
			e = 0;
		end
		return {10'(e), 1'b0, wide[77:54], wide[53:52], |wide[51:0]};
	endfunction

	assign accept = start_i && !busy_o;

	always_ff @(posedge clock) begin
		if (accept) begin
			want_flags <= special_flags(a_i, b_i, op_sqrt_i);
			{want_exponent, want_mantissa, want_grs} <= reference_value(a_i, b_i, op_sqrt_i);
			want_sign <= a_i[31] ^ (b_i[31] & ~op_sqrt_i);
			check_data <= is_normal(a_i) && (op_sqrt_i || is_normal(b_i));
		end
	end

	reset_check: assert property (@(posedge clock) !reset |=> !done_o && !busy_o)
		else begin
			error_count++;
			$error("Outputs done_o or busy_o not low after reset");
		end

	div_latency: assert property (@(posedge clock) disable iff (!reset)
		accept && !op_sqrt_i |-> ##1 (busy_o && !done_o) [*28] ##1 (busy_o && done_o)
			##1 (!busy_o && !done_o))
		else begin
			error_count++;
			$error("Divide did not finish exactly 28 cycles after its start");
		end

	sqrt_latency: assert property (@(posedge clock) disable iff (!reset)
		accept && op_sqrt_i |-> ##1 (busy_o && !done_o) [*27] ##1 (busy_o && done_o)
			##1 (!busy_o && !done_o))
		else begin
			error_count++;
			$error("Square root did not finish exactly 27 cycles after its start");
		end

	flags_check: assert property (@(posedge clock) disable iff (!reset)
		done_o |-> {snan_o, qnan_o, dbz_o, inf_o, zero_o} == want_flags)
		else begin
			error_count++;
			$error("ERROR flags got %h expected %h",
				$sampled({snan_o, qnan_o, dbz_o, inf_o, zero_o}), $sampled(want_flags));
		end

	sign_check: assert property (@(posedge clock) disable iff (!reset)
		done_o |-> sign_o == want_sign)
		else begin
			error_count++;
			$error("ERROR sign_o got %h expected %h", $sampled(sign_o), $sampled(want_sign));
		end

	exponent_check: assert property (@(posedge clock) disable iff (!reset)
		done_o && check_data |-> exponent_o == want_exponent)
		else begin
			error_count++;
			$error("ERROR exponent_o got %h expected %h",
				$sampled(exponent_o), $sampled(want_exponent));
		end

	mantissa_check: assert property (@(posedge clock) disable iff (!reset)
		done_o && check_data |-> mantissa_o == want_mantissa)
		else begin
			error_count++;
			$error("ERROR mantissa_o got %h expected %h",
				$sampled(mantissa_o), $sampled(want_mantissa));
		end

	grs_check: assert property (@(posedge clock) disable iff (!reset)
		done_o && check_data |-> grs_o == want_grs)
		else begin
			error_count++;
			$error("ERROR grs_o got %h expected %h", $sampled(grs_o), $sampled(want_grs));
		end

endmodule

bind fp_fdiv_top fp_fdiv_assertions u_assertions (.*);

// ==== verification/tb_fp_fdiv.sv ====
`timescale 1ns/1ps

module tb_fp_fdiv
	import fdiv_pkg::*;
();

	localparam int NUM_OPS = 36;
	localparam int CYCLE_LIMIT = NUM_OPS * 40 + 100;

	logic clock;
	logic reset;
	logic start_i;
	logic op_sqrt_i;
	logic [FP_WIDTH-1:0] a_i;
	logic [FP_WIDTH-1:0] b_i;
	logic busy_o;
	logic done_o;
	logic sign_o;
	logic [CALC_EXP_WIDTH-1:0] exponent_o;
	logic [RND_MANT_WIDTH-1:0] mantissa_o;
	logic [GRS_WIDTH-1:0] grs_o;
	logic snan_o;
	logic qnan_o;
	logic dbz_o;
	logic inf_o;
	logic zero_o;
	int op_count;
	int cycle_count;

	fp_fdiv_top u_fp_fdiv_top (
		.clock      (clock),
		.reset      (reset),
		.start_i    (start_i),
		.op_sqrt_i  (op_sqrt_i),
		.a_i        (a_i),
		.b_i        (b_i),
		.busy_o     (busy_o),
		.done_o     (done_o),
		.sign_o     (sign_o),
		.exponent_o (exponent_o),
		.mantissa_o (mantissa_o),
		.grs_o      (grs_o),
		.snan_o     (snan_o),
		.qnan_o     (qnan_o),
		.dbz_o      (dbz_o),
		.inf_o      (inf_o),
		.zero_o     (zero_o)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [FP_WIDTH-1:0] random_normal(input int exp_lo, input int exp_span);
		logic [FP_WIDTH-1:0] x;
		x = $urandom;
		x[30:23] = 8'(exp_lo + int'($urandom % exp_span));
		return x;
	endfunction

	task automatic run_op(input logic sqrt, input logic [FP_WIDTH-1:0] a,
			input logic [FP_WIDTH-1:0] b);
		int gap;
		gap = 1 + int'($urandom % 20);
		@(posedge clock);
		start_i <= 1'b1;
		op_sqrt_i <= sqrt;
		a_i <= a;
		b_i <= b;
		@(posedge clock);
		start_i <= 1'b0;
		repeat (gap) @(posedge clock);
		start_i <= 1'b1; // Lands while busy.
		op_sqrt_i <= ~sqrt;
		a_i <= $urandom;
		b_i <= $urandom;
		@(posedge clock);
		start_i <= 1'b0;
		do begin
			@(negedge clock);
		end while (!done_o);
		op_count++;
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, done_o never came for operation %0d",
			cycle_count, op_count + 1);
		$display("Test failures found");
		$finish;
	end

	initial begin
		void'($urandom(92));
		reset = 1'b0;
		start_i = 1'b0;
		op_sqrt_i = 1'b0;
		a_i = '0;
		b_i = '0;
		op_count = 0;
		repeat (2) @(posedge clock);
		reset <= 1'b1;

		run_op(1'b0, 32'h40c0_0000, 32'h4040_0000); // 6 / 3.
		run_op(1'b0, 32'h3f80_0000, 32'h4040_0000);
		run_op(1'b0, 32'h40e0_0000, 32'h4000_0000);
		run_op(1'b0, 32'hc110_0000, 32'h4080_0000); // -9 / 4.
		for (int i = 0; i < 8; i++) begin
			run_op(1'b0, random_normal(64, 128), random_normal(64, 128));
		end

		// Quotients below the normal range.
		run_op(1'b0, {1'b0, 8'd10, 23'h2a_5c31}, {1'b0, 8'd140, 23'h11_0f00});
		run_op(1'b0, {1'b0, 8'd1, 23'h7f_0000}, {1'b0, 8'd128, 23'h00_0001});
		run_op(1'b0, {1'b0, 8'd1, 23'h12_3456}, {1'b0, 8'd200, 23'h65_4321});

		run_op(1'b1, 32'h4080_0000, 32'h0);
		run_op(1'b1, 32'h4000_0000, 32'h0);
		run_op(1'b1, 32'h4110_0000, 32'h0);
		for (int i = 0; i < 5; i++) begin
			run_op(1'b1, random_normal(1, 254) & 32'h7fff_ffff, $urandom);
		end

		run_op(1'b0, 32'h7fc0_0000, 32'h3f80_0000);
		run_op(1'b0, 32'h3f80_0000, 32'h7f80_0001);
		run_op(1'b0, 32'h0000_0000, 32'h8000_0000);
		run_op(1'b0, 32'h7f80_0000, 32'hff80_0000);
		run_op(1'b0, 32'h3f80_0000, 32'h0000_0000);
		run_op(1'b0, 32'h7f80_0000, 32'h4000_0000);
		run_op(1'b0, 32'h0000_0000, 32'h40a0_0000);
		run_op(1'b0, 32'h40a0_0000, 32'h7f80_0000);
		run_op(1'b1, 32'hc080_0000, 32'h0);
		run_op(1'b1, 32'h7f80_0000, 32'h0);
		run_op(1'b1, 32'hff80_0000, 32'h0);
		run_op(1'b1, 32'h8000_0000, 32'h0);
		run_op(1'b1, 32'h7fc0_0000, 32'h0);

		repeat (3) @(posedge clock);
		$display("Operations run: %0d of %0d, assertion errors: %0d",
			op_count, NUM_OPS, u_fp_fdiv_top.u_assertions.error_count);
		if (u_fp_fdiv_top.u_assertions.error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== fp_fdiv.f ====
hw/fdiv_pkg.sv
hw/fdiv_operand_if.sv
hw/fdiv_operand_stage.sv
hw/fdiv_iterate.sv
hw/fdiv_normalize.sv
hw/fp_fdiv_top.sv
verification/fp_fdiv_assertions.sv
verification/tb_fp_fdiv.sv
